/* rtl/dptx_ctl_pkg.sv */
// Shared widths, control field positions, credit depth and state types for the DP TX control path
package dptx_ctl_pkg;

    // Message link
    localparam int MSG_DAT_W = 16;          // Data bits per message word
    localparam int MSG_IDX_W = 5;           // Payload index width
    localparam int MSG_ID_W  = 4;           // ID field, low bits of the header data

    // Control register layout
    localparam int CTL_W       = 6;
    localparam int CTL_LANES   = 0;         // Low bit of the 2-bit lane field
    localparam int CTL_TRN_SEL = 2;
    localparam int CTL_VID_EN  = 3;
    localparam int CTL_EFM     = 4;
    localparam int CTL_SCRM_EN = 5;

    // Credit loop
    localparam int CREDITS = 4;                         // FIFO depth and initial credits
    localparam int CRD_W   = $clog2(CREDITS + 1);       // Holds 0 .. CREDITS
    localparam int PTR_W   = (CREDITS > 1) ? $clog2(CREDITS) : 1;

    // Framer position within a message
    typedef enum logic [1:0] {
        FR_IDLE,    // Between messages
        FR_HDR,     // Header sent, payload expected
        FR_DATA     // Inside payload
    } framer_state_e;

    // Egress filter
    typedef enum logic [1:0] {
        EG_IDLE,    // Waiting for a header
        EG_PASS,    // Header matched own ID
        EG_DROP     // Header for another block
    } egress_state_e;

    // Active lane code
    typedef enum logic [1:0] {
        NONE = 2'd0,
        L1   = 2'd1,
        L2   = 2'd2,
        L4   = 2'd3
    } lanes_e;

endpackage

/* rtl/msg_framer.sv */
// Producer stage: frames host words onto the message link and spends one credit per word
`timescale 1ns/1ps

module msg_framer
(
    input  logic                                RST_IN,         // Clock
    input  logic                                CLK_IN,         // Async reset, active high
    input  logic                                host_vld,
    input  logic                                host_first,
    input  logic                                host_last,
    input  logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  host_dat,
    output logic                                host_rdy,
    output logic                                link_vld,
    output logic                                link_first,
    output logic                                link_last,
    output logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  link_dat,
    input  logic                                credit_ret      // One credit back from FIFO
);
    import dptx_ctl_pkg::*;

    framer_state_e      state;
    logic [CRD_W-1:0]   crd_cnt;
    logic               accept;
    logic               is_hdr;

    assign host_rdy = (crd_cnt != '0);              // Back-pressure only when credits run out
    assign accept   = host_vld && host_rdy;
    assign is_hdr   = host_first || (state == FR_IDLE);  // First word after a message is a header

    // Credit counter, spend on accept and refill on return
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            crd_cnt <= CRD_W'(CREDITS);
        else
            crd_cnt <= crd_cnt - CRD_W'(accept) + CRD_W'(credit_ret);
    end

    // Message position and link marks
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            state      <= FR_IDLE;
            link_vld   <= 1'b0;
            link_first <= 1'b0;
            link_last  <= 1'b0;
        end
        else
        begin
            link_vld   <= accept;
            link_first <= accept && is_hdr;
            link_last  <= accept && host_last;
            if (accept)
            begin
                if (host_last)
                    state <= FR_IDLE;       // Message closed
                else if (is_hdr)
                    state <= FR_HDR;
                else
                    state <= FR_DATA;
            end
        end
    end

    // Link payload
    always_ff @(posedge RST_IN)
    begin
        if (accept)
            link_dat <= host_dat;
    end

    a_credit_range : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        crd_cnt <= CRD_W'(CREDITS));
    // All credits home means no word left to return
    a_credit_owed : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        credit_ret |-> crd_cnt != CRD_W'(CREDITS));
    a_hdr_between_msgs : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        (accept && host_first) |-> state == FR_IDLE);   // Header only outside a message

endmodule

/* rtl/msg_fifo.sv */
// Buffer stage: stores link words, drains one per cycle and returns a credit for each pop
`timescale 1ns/1ps

module msg_fifo
(
    input  logic                                RST_IN,         // Clock
    input  logic                                CLK_IN,         // Async reset, active high
    input  logic                                link_vld,
    input  logic                                link_first,
    input  logic                                link_last,
    input  logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  link_dat,
    output logic                                fifo_vld,
    output logic                                fifo_first,
    output logic                                fifo_last,
    output logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  fifo_dat,
    output logic                                credit_ret
);
    import dptx_ctl_pkg::*;

    logic [MSG_DAT_W+1:0]   mem [CREDITS];      // {first, last, dat}
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CRD_W-1:0]       fill;
    logic                   push;
    logic                   pop;

    assign push = link_vld;
    assign pop  = (fill != '0);                 // Egress never stalls

    // Pointers, fill level and credit pulse
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            fifo_vld   <= 1'b0;
            credit_ret <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            fill       <= fill + CRD_W'(push) - CRD_W'(pop);
            fifo_vld   <= pop;
            credit_ret <= pop;                  // One cycle after the pop
        end
    end

    // Storage
    always_ff @(posedge RST_IN)
    begin
        if (push)
            mem[wr_ptr] <= {link_first, link_last, link_dat};
    end

    // Output word
    always_ff @(posedge RST_IN)
    begin
        if (pop)
            {fifo_first, fifo_last, fifo_dat} <= mem[rd_ptr];
    end

    a_no_write_full : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        link_vld |-> fill != CRD_W'(CREDITS));

endmodule

/* rtl/msg_egress.sv */
// Consumer stage: keeps messages addressed to ctl_id and emits their payload words with an index
`timescale 1ns/1ps

module msg_egress
#(
    parameter int unsigned ctl_id = 0                           // Own message ID
)
(
    input  logic                                RST_IN,         // Clock
    input  logic                                CLK_IN,         // Async reset, active high
    input  logic                                fifo_vld,
    input  logic                                fifo_first,
    input  logic                                fifo_last,
    input  logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  fifo_dat,
    output logic                                egr_vld,
    output logic [dptx_ctl_pkg::MSG_IDX_W-1:0]  egr_idx,
    output logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  egr_dat
);
    import dptx_ctl_pkg::*;

    egress_state_e          state;
    logic [MSG_IDX_W-1:0]   idx;        // Index of next payload word
    logic                   id_hit;

    assign id_hit = (fifo_dat[MSG_ID_W-1:0] == MSG_ID_W'(ctl_id));

    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            state   <= EG_IDLE;
            idx     <= '0;
            egr_vld <= 1'b0;
        end
        else
        begin
            egr_vld <= fifo_vld && (state == EG_PASS);
            if (fifo_vld)
            begin
                case (state)
                    EG_IDLE:
                    begin
                        idx <= '0;
                        if (fifo_first && !fifo_last)           // Header only message ends here
                            state <= id_hit ? EG_PASS : EG_DROP;
                    end
                    EG_PASS:
                    begin
                        if (idx != '1)
                            idx <= idx + 1'b1;                  // Saturate, high indices unused
                        if (fifo_last)
                            state <= EG_IDLE;
                    end
                    default:                                    // Drop
                    begin
                        if (fifo_last)
                            state <= EG_IDLE;
                    end
                endcase
            end
        end
    end

    // Payload out
    always_ff @(posedge RST_IN)
    begin
        if (fifo_vld && (state == EG_PASS))
        begin
            egr_idx <= idx;
            egr_dat <= fifo_dat;
        end
    end

    a_first_in_idle : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        (fifo_vld && fifo_first) |-> state == EG_IDLE);

endmodule

/* rtl/dptx_ctl.sv */
// Control register block: a mask at index 0 gates writes of the transmitter control bits at index 1
`timescale 1ns/1ps

module dptx_ctl
(
    input  logic                                RST_IN,         // Clock
    input  logic                                CLK_IN,         // Async reset, active high
    input  logic                                egr_vld,
    input  logic [dptx_ctl_pkg::MSG_IDX_W-1:0]  egr_idx,
    input  logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  egr_dat,
    output dptx_ctl_pkg::lanes_e                ctl_lanes,      // Active lane count
    output logic                                ctl_trn_sel,    // Training select
    output logic                                ctl_vid_en,     // Video enable
    output logic                                ctl_efm,        // Enhanced framing
    output logic                                ctl_scrm_en     // Scrambler enable
);
    import dptx_ctl_pkg::*;

    logic [CTL_W-1:0]   msk_reg;    // Write mask for control bits
    logic [CTL_W-1:0]   ctl_reg;
    logic [CTL_W-1:0]   wr_bits;

    assign wr_bits = egr_dat[CTL_W-1:0];

    // Mask at index 0
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            msk_reg <= '0;
        else if (egr_vld && (egr_idx == MSG_IDX_W'(0)))
            msk_reg <= wr_bits;
    end

    // Control at index 1
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            ctl_reg <= '0;
        else if (egr_vld && (egr_idx == MSG_IDX_W'(1)))
            ctl_reg <= (ctl_reg & ~msk_reg) | (wr_bits & msk_reg);    // Masked bits only
    end

    // Field slices
    assign ctl_lanes   = lanes_e'(ctl_reg[CTL_LANES +: 2]);
    assign ctl_trn_sel = ctl_reg[CTL_TRN_SEL];
    assign ctl_vid_en  = ctl_reg[CTL_VID_EN];
    assign ctl_efm     = ctl_reg[CTL_EFM];
    assign ctl_scrm_en = ctl_reg[CTL_SCRM_EN];

endmodule

/* rtl/dptx_ctl_top.sv */
// Top level of the DP TX control path: host words in, transmitter control outputs out
`timescale 1ns/1ps

module dptx_ctl_top
#(
    parameter int unsigned ctl_id = 0                           // ID of the control block
)
(
    input  logic                                RST_IN,         // Clock
    input  logic                                CLK_IN,         // Async reset, active high
    input  logic                                host_vld,
    input  logic                                host_first,
    input  logic                                host_last,
    input  logic [dptx_ctl_pkg::MSG_DAT_W-1:0]  host_dat,
    output logic                                host_rdy,
    output dptx_ctl_pkg::lanes_e                ctl_lanes,
    output logic                                ctl_trn_sel,
    output logic                                ctl_vid_en,
    output logic                                ctl_efm,
    output logic                                ctl_scrm_en
);
    import dptx_ctl_pkg::*;

    // Framer to FIFO
    logic                   link_vld;
    logic                   link_first;
    logic                   link_last;
    logic [MSG_DAT_W-1:0]   link_dat;
    logic                   credit_ret;

    // FIFO to egress
    logic                   fifo_vld;
    logic                   fifo_first;
    logic                   fifo_last;
    logic [MSG_DAT_W-1:0]   fifo_dat;

    // Egress to control block
    logic                   egr_vld;
    logic [MSG_IDX_W-1:0]   egr_idx;
    logic [MSG_DAT_W-1:0]   egr_dat;

    msg_framer u_framer (.*);                       // Host side, credit owner

    msg_fifo u_fifo (.*);

    msg_egress #(.ctl_id(ctl_id)) u_egress (.*);    // ID filter

    dptx_ctl u_ctl (.*);

endmodule

/* verification/tb_dptx_ctl.sv */
// Trace-driven testbench for the DP TX control path, compiled from flist.f with tb_dptx_ctl as top
`timescale 1ns/1ps

module tb_dptx_ctl;
    import dptx_ctl_pkg::*;

    logic                   RST_IN;         // Clock
    logic                   CLK_IN;         // Reset, active high
    logic                   host_vld;
    logic                   host_first;
    logic                   host_last;
    logic [MSG_DAT_W-1:0]   host_dat;
    logic                   host_rdy;
    lanes_e                 ctl_lanes;
    logic                   ctl_trn_sel;
    logic                   ctl_vid_en;
    logic                   ctl_efm;
    logic                   ctl_scrm_en;

    string      lines[$];                   // W, C and G lines of the trace
    string      line;
    integer     fd;
    integer     seed = 32'hf409_501f;       // Idle gap generator
    int         limit = 100;                // Timeout in cycles
    int         cycles = 0;
    int         max_gap = 2;
    int         test_no = 0;
    int         test_errs = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    int         code;
    int         f, l, d, gap;
    int         e_lanes, e_trn, e_vid, e_efm, e_scrm;
    byte        tag;

    dptx_ctl_top #(.ctl_id(0)) DUT (.*);

    initial
    begin
        RST_IN = 1'b0;
        forever #10 RST_IN = ~RST_IN;       // 20 ns period
    end

    // Run limit
    always @(posedge RST_IN)
    begin
        cycles = cycles + 1;
        if (cycles >= limit)
        begin
            $display("Run timed out after %0d cycles, DUT stopped accepting host words", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_lanes(input string name, input lanes_e exp, input lanes_e act);
        if (act !== exp)
        begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            test_errs++;
        end
    endtask

    // Each wait ends 1 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge RST_IN);
            #1;
        end
    endtask

    // Hold the word until an edge sees host_rdy
    task automatic send_word(input logic first, input logic last, input logic [MSG_DAT_W-1:0] dat);
        logic rdy_now;
        host_vld   = 1'b1;
        host_first = first;
        host_last  = last;
        host_dat   = dat;
        check_flag("host_rdy", 1'b1, host_rdy);     // Four credits cover the 3-cycle loop
        do
        begin
            rdy_now = host_rdy;             // Stable until the next edge
            idle_cycles(1);
        end
        while (!rdy_now);
        host_vld = 1'b0;
    endtask

    // Pipeline latency is 4 cycles from the last accepted word
    task automatic finish_test(input int lanes, input int trn, input int vid, input int efm,
                               input int scrm);
        idle_cycles(4);
        test_no++;
        check_flag("host_rdy", 1'b1, host_rdy);
        check_lanes("ctl_lanes", lanes_e'(lanes), ctl_lanes);
        check_flag("ctl_trn_sel", trn[0], ctl_trn_sel);
        check_flag("ctl_vid_en", vid[0], ctl_vid_en);
        check_flag("ctl_efm", efm[0], ctl_efm);
        check_flag("ctl_scrm_en", scrm[0], ctl_scrm_en);
        if (test_errs == 0)
        begin
            pass_cnt++;
            $display("Test %0d pass", test_no);
        end
        else
        begin
            fail_cnt++;
            $display("Test %0d fail with %0d mismatches", test_no, test_errs);
        end
        test_errs = 0;                      // Word checks count toward the next test
    endtask

    // Keep only lines that start with a record tag
    task automatic load_trace();
        fd = $fopen("verification/dptx_ctl_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file verification/dptx_ctl_trace.txt");
            fail_cnt++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 0)
                    if (line.getc(0) == "W" || line.getc(0) == "C" || line.getc(0) == "G")
                        lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        CLK_IN     = 1'b1;                  // In reset from time 0
        host_vld   = 1'b0;
        host_first = 1'b0;
        host_last  = 1'b0;
        host_dat   = '0;
        load_trace();
        limit = 40 * lines.size() + 100;
        repeat (4) @(posedge RST_IN);
        #1 CLK_IN = 1'b0;
        foreach (lines[i])
        begin
            tag = lines[i].getc(0);
            if (tag == "W")
            begin
                code = $sscanf(lines[i], "W %d %d %h", f, l, d);
                gap  = $unsigned($random(seed)) % (max_gap + 1);
                idle_cycles(gap);
                send_word(f[0], l[0], d[MSG_DAT_W-1:0]);
            end
            else if (tag == "G")
                code = $sscanf(lines[i], "G %d", max_gap);      // Gap limit for later words
            else
            begin
                code = $sscanf(lines[i], "C %d %d %d %d %d", e_lanes, e_trn, e_vid, e_efm, e_scrm);
                finish_test(e_lanes, e_trn, e_vid, e_efm, e_scrm);
            end
        end
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verification/dptx_ctl_trace.txt */
# W first last data_hex = one host word, G max_gap = idle cycles allowed before each later word
# C lanes trn_sel vid_en efm scrm_en = expected control outputs, closes a test
G 2
# Reset values
C 0 0 0 0 0
# Full mask, control 0x3B
W 1 0 0000
W 0 0 003F
W 0 1 003B
C 3 0 1 1 1
# Mask 0x08 clears video enable only
W 1 0 0000
W 0 0 0008
W 0 1 0000
C 3 0 0 1 1
# Header for ID 5 is dropped
W 1 0 0005
W 0 0 003F
W 0 1 0000
C 3 0 0 1 1
# Words past index 1 have no effect
W 1 0 0000
W 0 0 003F
W 0 0 0004
W 0 0 003B
W 0 1 003F
C 0 1 0 0 0
# Back-to-back messages, one for ID 3
G 0
W 1 0 0000
W 0 0 003F
W 0 1 0001
W 1 0 0000
W 0 0 0030
W 0 1 0030
W 1 0 0003
W 0 0 003F
W 0 1 0000
W 1 0 0000
W 0 0 000C
W 0 1 0008
C 1 0 1 1 1

/* flist.f */
rtl/dptx_ctl_pkg.sv
rtl/msg_framer.sv
rtl/msg_fifo.sv
rtl/msg_egress.sv
rtl/dptx_ctl.sv
rtl/dptx_ctl_top.sv
verification/tb_dptx_ctl.sv

/* Bender.yml */
package:
  name: dptx_ctl

sources:
  - rtl/dptx_ctl_pkg.sv
  - rtl/msg_framer.sv
  - rtl/msg_fifo.sv
  - rtl/msg_egress.sv
  - rtl/dptx_ctl.sv
  - rtl/dptx_ctl_top.sv
  - target: test
    files:
      - verification/tb_dptx_ctl.sv
